// ==== dv/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk_1
);

    initial begin
        clk_1 = 1'b0;
    end

    // 40 ns period
    always begin
        #20 clk_1 = ~clk_1;
    end

endmodule

`default_nettype wire

// ==== dv/mem_vectors.txt ====
# W ctrl addr data | R addr expected
# L start_word count words... | U start_word count expected_words...
W 4 000 11223344
W 4 004 55667788
W 1 001 000000aa
W 2 006 0000bbcc
R 000 1122aa44
R 004 bbcc7788
W 2 003 0000ddee
R 002 77ddee22
W 4 010 01020304
W 4 014 05060708
W 4 011 a1b2c3d4
R 010 b2c3d404
R 014 050607a1
W 4 016 f0e0d0c0
R 015 e0d0c007
W 4 ffc 0a0b0c0d
W 4 fff 99887766
R ffd 77660b0c
R 000 ee998877
W 3 010 deadbeef
R 010 b2c3d404
L 020 2 cafef00d 12345678 0badc0de
R 080 cafef00d
R 088 0badc0de
R 086 c0de1234
U 004 1 b2c3d404 d0c007a1
U 021 1 12345678 0badc0de
U 000 0 ee998877

// ==== dv/tb_mem_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_scan;
    import mem_pkg::*;

    logic        clk_1;
    logic        rst_n_sync;
    logic        mem_en;
    byte_addr_t  mem_addr;
    data_word_t  mem_din;
    store_ctrl_t storecntrl;
    data_word_t  mem_dout;
    logic        scan_en;
    logic        scan_in;
    logic        scan_out;
    logic        scan_valid;

    // Parsed vectors with one entry per operation
    logic [7:0]  op_q[$];
    logic [31:0] arg_a[$];
    logic [31:0] arg_b[$];
    logic [31:0] arg_c[$];
    int          word_base[$];
    data_word_t  word_pool[$];
    bit          stream_q[$];
    lane_byte_t  model_mem [0:4095];
    int          tests_run;
    int          tests_failed;
    int          setup_errors;
    bit          vectors_ready;

    clk_gen clk_gen_inst (
        .clk_1 (clk_1)
    );

    mem_scan_top mem_scan_top_inst (
        .clk_1      (clk_1),
        .rst_n_sync (rst_n_sync),
        .mem_en     (mem_en),
        .mem_addr   (mem_addr),
        .mem_din    (mem_din),
        .storecntrl (storecntrl),
        .mem_dout   (mem_dout),
        .scan_en    (scan_en),
        .scan_in    (scan_in),
        .scan_out   (scan_out),
        .scan_valid (scan_valid)
    );

    // Little-endian word from four consecutive bytes that wrap at 4096
    function automatic data_word_t model_read(input byte_addr_t addr);
        data_word_t w;
        for (int j = 0; j < LANES; j++) begin
            w[8*j +: 8] = model_mem[12'(addr + j)];
        end
        return w;
    endfunction

    task automatic model_store(input store_ctrl_t ctrl, input byte_addr_t addr,
                               input data_word_t data);
        int n;
        case (ctrl)
            STORE_BYTE: n = 1;
            STORE_HALF: n = 2;
            STORE_WORD: n = 4;
            default:    n = 0;
        endcase
        for (int j = 0; j < n; j++) begin
            model_mem[12'(addr + j)] = data[8*j +: 8];
        end
    endtask

    task automatic load_vectors();
        int               fd;
        int               code;
        int               base;
        logic [8*16-1:0]  tok;
        logic [8*160-1:0] line;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      c;
        fd = $fopen("dv/mem_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file dv/mem_vectors.txt");
            setup_errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %s", tok);
            if (code != 1) begin
                break;
            end
            a    = '0;
            base = word_pool.size();
            if (tok[8*16-1:8] != '0) begin
                $display("Unknown token in the vector file");
                setup_errors++;
                code = $fgets(line, fd);
                continue;
            end
            case (tok[7:0])
                "#": begin
                    code = $fgets(line, fd);
                    continue;
                end
                "W": code = $fscanf(fd, " %h %h %h", a, b, c) - 3;
                "R": code = $fscanf(fd, " %h %h", b, c) - 2;
                "L", "U": begin
                    c    = '0;
                    code = $fscanf(fd, " %h %h", b, a) - 2;
                    for (int w = 0; w <= int'(a); w++) begin
                        if ($fscanf(fd, " %h", c) != 1) begin
                            code = -1;
                        end
                        word_pool.push_back(c);
                    end
                end
                default: code = -1;
            endcase
            if (code != 0) begin
                $display("Malformed vector number %0d", op_q.size());
                setup_errors++;
            end
            op_q.push_back(tok[7:0]);
            arg_a.push_back(a);
            arg_b.push_back(b);
            arg_c.push_back(c);
            word_base.push_back(base);
        end
        $fclose(fd);
    endtask

    task automatic cpu_store(input store_ctrl_t ctrl, input byte_addr_t addr,
                             input data_word_t data);
        mem_en     = 1'b1;
        storecntrl = ctrl;
        mem_addr   = addr;
        mem_din    = data;
        @(negedge clk_1);
        mem_en     = 1'b0;
        storecntrl = '0;
    endtask

    task automatic cpu_read(input byte_addr_t addr, output data_word_t rdata);
        mem_en     = 1'b1;
        storecntrl = '0;
        mem_addr   = addr;
        mem_din    = $urandom();
        @(negedge clk_1);
        mem_en = 1'b0;
        rdata  = mem_dout;
    endtask

    task automatic shift_in_bit(input logic b);
        scan_in = b;
        @(negedge clk_1);
    endtask

    // CPU store to the scan's own start word runs alongside and must be ignored
    task automatic start_scan(input logic [31:0] start, input int cnt, input logic we);
        logic [HDR_W-1:0] hdr;
        hdr        = {word_addr_t'(start), word_cnt_t'(cnt), we};
        scan_en    = 1'b1;
        mem_en     = 1'b1;
        storecntrl = STORE_WORD;
        mem_addr   = {word_addr_t'(start), 2'b00};
        mem_din    = $urandom();
        for (int i = 0; i < HDR_W; i++) begin
            shift_in_bit(hdr[i]);
        end
    endtask

    task automatic end_scan();
        scan_en    = 1'b0;
        scan_in    = 1'b0;
        mem_en     = 1'b0;
        storecntrl = '0;
        @(negedge clk_1);
    endtask

    task automatic scan_load(input logic [31:0] start, input int cnt, input int base);
        start_scan(start, cnt, 1'b1);
        for (int w = 0; w <= cnt; w++) begin
            for (int b = 0; b < WORD_W; b++) begin
                shift_in_bit(word_pool[base + w][b]);
            end
            // Commit slot where scan_in is a don't care
            shift_in_bit(1'($urandom()));
        end
        end_scan();
    endtask

    task automatic scan_unload(input logic [31:0] start, input int cnt);
        start_scan(start, cnt, 1'b0);
        scan_in = 1'b0;
        stream_q.delete();
        for (int c = 0; c < (cnt + 1) * (WORD_W + 2) + 8; c++) begin
            if (scan_valid) begin
                stream_q.push_back(scan_out);
            end
            @(negedge clk_1);
        end
        end_scan();
    endtask

    task automatic run_vector(input int idx);
        string      name;
        int         errs;
        int         cnt;
        int         base;
        data_word_t got;
        data_word_t exp;
        data_word_t ref_word;
        errs = 0;
        cnt  = int'(arg_a[idx]);
        base = word_base[idx];
        name = $sformatf("v%0d", idx);
        case (op_q[idx])
            "W": begin
                name = {name, "_store"};
                cpu_store(arg_a[idx][2:0], arg_b[idx][11:0], arg_c[idx]);
                model_store(arg_a[idx][2:0], arg_b[idx][11:0], arg_c[idx]);
            end
            "R": begin
                name     = {name, "_read"};
                exp      = arg_c[idx];
                ref_word = model_read(arg_b[idx][11:0]);
                if (ref_word !== exp) begin
                    $display("%s: vector value %h disagrees with byte model %h",
                             name, exp, ref_word);
                    errs++;
                end
                cpu_read(arg_b[idx][11:0], got);
                if (got !== exp) begin
                    $display("Fail %s expected %h actual %h", name, exp, got);
                    errs++;
                end
            end
            "L": begin
                name = {name, "_scan_load"};
                scan_load(arg_b[idx], cnt, base);
                for (int w = 0; w <= cnt; w++) begin
                    model_store(STORE_WORD, byte_addr_t'((arg_b[idx] + w) * 4),
                                word_pool[base + w]);
                end
            end
            "U": begin
                name = {name, "_scan_unload"};
                scan_unload(arg_b[idx], cnt);
                if (stream_q.size() != WORD_W * (cnt + 1)) begin
                    $display("Fail %s expected %0d valid bits actual %0d",
                             name, WORD_W * (cnt + 1), stream_q.size());
                    errs++;
                end else begin
                    for (int w = 0; w <= cnt; w++) begin
                        exp      = word_pool[base + w];
                        ref_word = model_read(byte_addr_t'((arg_b[idx] + w) * 4));
                        for (int b = 0; b < WORD_W; b++) begin
                            got[b] = stream_q[WORD_W * w + b];
                        end
                        if (ref_word !== exp) begin
                            $display("%s: vector value %h disagrees with byte model %h",
                                     name, exp, ref_word);
                            errs++;
                        end
                        if (got !== exp) begin
                            $display("Fail %s expected %h actual %h", name, exp, got);
                            errs++;
                        end
                    end
                end
            end
            default: begin
                $display("%s: unknown operation in the vector file", name);
                errs++;
            end
        endcase
        tests_run++;
        if (errs == 0) begin
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errs);
        end
    endtask

    initial begin
        void'($urandom(72221));
        rst_n_sync    = 1'b0;
        mem_en        = 1'b0;
        mem_addr      = '0;
        mem_din       = '0;
        storecntrl    = '0;
        scan_en       = 1'b0;
        scan_in       = 1'b0;
        tests_run     = 0;
        tests_failed  = 0;
        setup_errors  = 0;
        load_vectors();
        vectors_ready = 1'b1;
        repeat (8) @(negedge clk_1);
        rst_n_sync = 1'b1;
        @(negedge clk_1);
        tests_run++;
        if (scan_valid !== 1'b0 || scan_out !== 1'b0) begin
            $display("Fail reset expected 00 actual %b%b", scan_valid, scan_out);
            tests_failed++;
        end else begin
            $display("reset: pass");
        end
        for (int i = 0; i < op_q.size(); i++) begin
            run_vector(i);
        end
        $display("tests %0d, passed %0d, failed %0d, setup errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, setup_errors);
        if (tests_failed == 0 && setup_errors == 0 && op_q.size() > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog allows 1200 cycles per vector plus one share for reset
    initial begin
        wait (vectors_ready);
        #((op_q.size() + 1) * 1200 * 40);
        $display("Timeout, the run did not finish within the watchdog limit");
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/bit_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bit_counter (
    input  wire                     clk_1,
    input  wire                     rst_n_sync,
    input  wire                     bit_clr,
    input  wire                     bit_step,
    input  wire                     word_load,
    input  wire                     word_step,
    input  wire mem_pkg::word_cnt_t hdr_cnt,
    output logic                    hdr_full,
    output logic                    word_full,
    output logic                    last_word
);
    import mem_pkg::*;

    logic [$clog2(WORD_W):0] bit_cnt;
    word_cnt_t               words_left;

    always_ff @(posedge clk_1 or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            bit_cnt    <= '0;
            words_left <= '0;
        end else begin
            if (bit_clr) begin
                bit_cnt <= '0;
            end else if (bit_step) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            // Count field is words minus one
            if (word_load) begin
                words_left <= hdr_cnt;
            end else if (word_step) begin
                words_left <= words_left - 1'b1;
            end
        end
    end

    assign hdr_full  = (bit_cnt == HDR_W - 1);
    assign word_full = (bit_cnt == WORD_W - 1);
    assign last_word = (words_left == '0);

endmodule

`default_nettype wire

// ==== rtl/byte_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_bank (
    input  wire                      clk_1,
    input  wire                      en,
    input  wire                      we,
    input  wire mem_pkg::word_addr_t addr,
    input  wire mem_pkg::lane_byte_t din,
    output mem_pkg::lane_byte_t      dout
);
    import mem_pkg::*;

    lane_byte_t ram [1 << WORD_ADDR_W];

    // Read-first, a write returns the old byte
    always_ff @(posedge clk_1) begin
        if (en) begin
            if (we) begin
                ram[addr] <= din;
            end
            dout <= ram[addr];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lane_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_router (
    input  wire                                       mem_en,
    input  wire mem_pkg::byte_addr_t                  mem_addr,
    input  wire mem_pkg::data_word_t                  mem_din,
    input  wire mem_pkg::store_ctrl_t                 storecntrl,
    input  wire                                       scan_active,
    input  wire                                       scan_bank_en,
    input  wire                                       scan_bank_we,
    input  wire mem_pkg::word_addr_t                  scan_word_addr,
    input  wire mem_pkg::data_word_t                  scan_wdata,
    output mem_pkg::lane_mask_t                       lane_en,
    output mem_pkg::lane_mask_t                       lane_we,
    output mem_pkg::word_addr_t [mem_pkg::LANES-1:0]  lane_addr,
    output mem_pkg::lane_byte_t [mem_pkg::LANES-1:0]  lane_din
);
    import mem_pkg::*;

    word_addr_t         cpu_word;
    word_addr_t         cpu_next;
    logic [1:0]         cpu_off;
    lane_mask_t         base_mask;
    lane_mask_t         cpu_mask;
    logic [2*LANES-1:0] mask_rot;

    assign cpu_word = mem_addr[BYTE_ADDR_W-1:2];
    assign cpu_next = cpu_word + 1'b1;
    assign cpu_off  = mem_addr[1:0];

    always_comb begin
        case (storecntrl)
            STORE_BYTE: base_mask = 4'b0001;
            STORE_HALF: base_mask = 4'b0011;
            STORE_WORD: base_mask = 4'b1111;
            default:    base_mask = 4'b0000;
        endcase
    end

    // Mask rotated up to the offset, upper lanes wrap into lane 0
    assign mask_rot = {base_mask, base_mask} << cpu_off;
    assign cpu_mask = mask_rot[2*LANES-1:LANES];

    always_comb begin
        logic [1:0] src;
        for (int k = 0; k < LANES; k++) begin
            src = 2'(k) - cpu_off;
            if (scan_active) begin
                lane_addr[k] = scan_word_addr;
                lane_din[k]  = scan_wdata[8*k +: 8];
            end else begin
                // Lanes below the offset belong to the next word
                lane_addr[k] = (k < cpu_off) ? cpu_next : cpu_word;
                lane_din[k]  = mem_din[8*src +: 8];
            end
        end
    end

    assign lane_en = scan_active ? {LANES{scan_bank_en}} : {LANES{mem_en}};
    assign lane_we = scan_active ? {LANES{scan_bank_we}} : (mem_en ? cpu_mask : '0);

endmodule

`default_nettype wire

// ==== rtl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    localparam int BYTE_ADDR_W = 12;
    localparam int WORD_ADDR_W = 10;
    localparam int LANES       = 4;
    localparam int WORD_W      = 32;
    localparam int CNT_W       = 8;
    localparam int HDR_W       = 1 + CNT_W + WORD_ADDR_W;

    // One-hot store controls, any other code is no write
    localparam logic [2:0] STORE_BYTE = 3'b001;
    localparam logic [2:0] STORE_HALF = 3'b010;
    localparam logic [2:0] STORE_WORD = 3'b100;

    typedef logic [BYTE_ADDR_W-1:0] byte_addr_t;
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;
    typedef logic [WORD_W-1:0]      data_word_t;
    typedef logic [7:0]             lane_byte_t;
    typedef logic [LANES-1:0]       lane_mask_t;
    typedef logic [2:0]             store_ctrl_t;
    typedef logic [CNT_W-1:0]       word_cnt_t;

    typedef enum logic [2:0] {
        SCAN_HEADER,
        SCAN_WR_SHIFT,
        SCAN_WR_COMMIT,
        SCAN_RD_FETCH,
        SCAN_RD_LOAD,
        SCAN_RD_SHIFT,
        SCAN_DONE
    } scan_state_t;

endpackage

`default_nettype wire

// ==== rtl/mem_scan_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_scan_top (
    input  wire                       clk_1,
    input  wire                       rst_n_sync,
    input  wire                       mem_en,
    input  wire mem_pkg::byte_addr_t  mem_addr,
    input  wire mem_pkg::data_word_t  mem_din,
    input  wire mem_pkg::store_ctrl_t storecntrl,
    output wire mem_pkg::data_word_t  mem_dout,
    input  wire                       scan_en,
    input  wire                       scan_in,
    output wire                       scan_out,
    output wire                       scan_valid
);
    import mem_pkg::*;

    wire lane_mask_t               lane_en;
    wire lane_mask_t               lane_we;
    wire word_addr_t [LANES-1:0]   lane_addr;
    wire lane_byte_t [LANES-1:0]   lane_din;
    wire lane_byte_t [LANES-1:0]   lane_dout;
    wire                           scan_active;
    wire                           scan_bank_en;
    wire                           scan_bank_we;
    wire word_addr_t               scan_word_addr;
    wire data_word_t               scan_wdata;
    wire                           hdr_we;
    wire word_cnt_t                hdr_cnt;
    wire word_addr_t               hdr_addr;
    wire                           bit_clr;
    wire                           bit_step;
    wire                           word_load;
    wire                           word_step;
    wire                           hdr_full;
    wire                           word_full;
    wire                           last_word;
    wire                           hdr_shift;
    wire                           data_shift;
    wire                           out_load;
    wire                           out_shift;
    wire [1:0]                     rd_offset;

    // Scan accesses are always word aligned
    assign rd_offset = scan_active ? 2'b00 : mem_addr[1:0];

    for (genvar k = 0; k < LANES; k++) begin : g_bank
        byte_bank bank_inst (
            .clk_1 (clk_1),
            .en    (lane_en[k]),
            .we    (lane_we[k]),
            .addr  (lane_addr[k]),
            .din   (lane_din[k]),
            .dout  (lane_dout[k])
        );
    end

    lane_router lane_router_inst (
        .mem_en         (mem_en),
        .mem_addr       (mem_addr),
        .mem_din        (mem_din),
        .storecntrl     (storecntrl),
        .scan_active    (scan_active),
        .scan_bank_en   (scan_bank_en),
        .scan_bank_we   (scan_bank_we),
        .scan_word_addr (scan_word_addr),
        .scan_wdata     (scan_wdata),
        .lane_en        (lane_en),
        .lane_we        (lane_we),
        .lane_addr      (lane_addr),
        .lane_din       (lane_din)
    );

    read_aligner read_aligner_inst (
        .clk_1      (clk_1),
        .rst_n_sync (rst_n_sync),
        .capture    (lane_en[0]),
        .offset     (rd_offset),
        .lane_dout  (lane_dout),
        .rdata      (mem_dout)
    );

    scan_sequencer scan_sequencer_inst (
        .clk_1          (clk_1),
        .rst_n_sync     (rst_n_sync),
        .scan_en        (scan_en),
        .hdr_we         (hdr_we),
        .hdr_addr       (hdr_addr),
        .hdr_full       (hdr_full),
        .word_full      (word_full),
        .last_word      (last_word),
        .scan_active    (scan_active),
        .scan_bank_en   (scan_bank_en),
        .scan_bank_we   (scan_bank_we),
        .scan_word_addr (scan_word_addr),
        .bit_clr        (bit_clr),
        .bit_step       (bit_step),
        .word_load      (word_load),
        .word_step      (word_step),
        .hdr_shift      (hdr_shift),
        .data_shift     (data_shift),
        .out_load       (out_load),
        .out_shift      (out_shift),
        .scan_valid     (scan_valid)
    );

    bit_counter bit_counter_inst (
        .clk_1      (clk_1),
        .rst_n_sync (rst_n_sync),
        .bit_clr    (bit_clr),
        .bit_step   (bit_step),
        .word_load  (word_load),
        .word_step  (word_step),
        .hdr_cnt    (hdr_cnt),
        .hdr_full   (hdr_full),
        .word_full  (word_full),
        .last_word  (last_word)
    );

    scan_shifter scan_shifter_inst (
        .clk_1      (clk_1),
        .rst_n_sync (rst_n_sync),
        .scan_in    (scan_in),
        .hdr_shift  (hdr_shift),
        .data_shift (data_shift),
        .out_load   (out_load),
        .out_shift  (out_shift),
        .rdata      (mem_dout),
        .hdr_we     (hdr_we),
        .hdr_cnt    (hdr_cnt),
        .hdr_addr   (hdr_addr),
        .scan_wdata (scan_wdata),
        .scan_out   (scan_out)
    );

endmodule

`default_nettype wire

// ==== rtl/read_aligner.sv ====
`timescale 1ns/1ps
`default_nettype none

module read_aligner (
    input  wire                                      clk_1,
    input  wire                                      rst_n_sync,
    input  wire                                      capture,
    input  wire [1:0]                                offset,
    input  wire mem_pkg::lane_byte_t [mem_pkg::LANES-1:0] lane_dout,
    output mem_pkg::data_word_t                      rdata
);
    import mem_pkg::*;

    logic [1:0] off_q;

    always_ff @(posedge clk_1 or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            off_q <= 2'b00;
        end else if (capture) begin
            off_q <= offset;
        end
    end

    // Byte j of the word sits in lane (offset + j) mod 4
    always_comb begin
        logic [1:0] lane;
        for (int j = 0; j < LANES; j++) begin
            lane = off_q + 2'(j);
            rdata[8*j +: 8] = lane_dout[lane];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/scan_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module scan_sequencer (
    input  wire                      clk_1,
    input  wire                      rst_n_sync,
    input  wire                      scan_en,
    input  wire                      hdr_we,
    input  wire mem_pkg::word_addr_t hdr_addr,
    input  wire                      hdr_full,
    input  wire                      word_full,
    input  wire                      last_word,
    output logic                     scan_active,
    output logic                     scan_bank_en,
    output logic                     scan_bank_we,
    output mem_pkg::word_addr_t      scan_word_addr,
    output logic                     bit_clr,
    output logic                     bit_step,
    output logic                     word_load,
    output logic                     word_step,
    output logic                     hdr_shift,
    output logic                     data_shift,
    output logic                     out_load,
    output logic                     out_shift,
    output logic                     scan_valid
);
    import mem_pkg::*;

    scan_state_t state_q;
    scan_state_t state_d;
    word_addr_t  addr_q;

    always_comb begin
        state_d      = state_q;
        bit_clr      = 1'b0;
        bit_step     = 1'b0;
        word_load    = 1'b0;
        word_step    = 1'b0;
        hdr_shift    = 1'b0;
        data_shift   = 1'b0;
        out_load     = 1'b0;
        out_shift    = 1'b0;
        scan_bank_en = 1'b0;
        scan_bank_we = 1'b0;
        if (!scan_en) begin
            state_d = SCAN_HEADER;
            bit_clr = 1'b1;
        end else begin
            case (state_q)
                SCAN_HEADER: begin
                    hdr_shift = 1'b1;
                    bit_step  = 1'b1;
                    // Last header bit arrives on this edge
                    if (hdr_full) begin
                        bit_clr   = 1'b1;
                        word_load = 1'b1;
                        state_d   = hdr_we ? SCAN_WR_SHIFT : SCAN_RD_FETCH;
                    end
                end
                SCAN_WR_SHIFT: begin
                    data_shift = 1'b1;
                    bit_step   = 1'b1;
                    if (word_full) begin
                        bit_clr = 1'b1;
                        state_d = SCAN_WR_COMMIT;
                    end
                end
                SCAN_WR_COMMIT: begin
                    scan_bank_en = 1'b1;
                    scan_bank_we = 1'b1;
                    if (last_word) begin
                        state_d = SCAN_DONE;
                    end else begin
                        word_step = 1'b1;
                        state_d   = SCAN_WR_SHIFT;
                    end
                end
                SCAN_RD_FETCH: begin
                    scan_bank_en = 1'b1;
                    state_d      = SCAN_RD_LOAD;
                end
                SCAN_RD_LOAD: begin
                    out_load = 1'b1;
                    state_d  = SCAN_RD_SHIFT;
                end
                SCAN_RD_SHIFT: begin
                    out_shift = 1'b1;
                    bit_step  = 1'b1;
                    if (word_full) begin
                        bit_clr = 1'b1;
                        if (last_word) begin
                            state_d = SCAN_DONE;
                        end else begin
                            word_step = 1'b1;
                            state_d   = SCAN_RD_FETCH;
                        end
                    end
                end
                SCAN_DONE: begin
                    state_d = SCAN_DONE;
                end
                default: begin
                    state_d = SCAN_HEADER;
                end
            endcase
        end
    end

    always_ff @(posedge clk_1 or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            state_q <= SCAN_HEADER;
            addr_q  <= '0;
        end else begin
            state_q <= state_d;
            if (word_load) begin
                addr_q <= hdr_addr;
            end else if (word_step) begin
                addr_q <= addr_q + 1'b1;
            end
        end
    end

    assign scan_active    = scan_en;
    assign scan_word_addr = addr_q;
    assign scan_valid     = (state_q == SCAN_RD_SHIFT);

endmodule

`default_nettype wire

// ==== rtl/scan_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module scan_shifter (
    input  wire                      clk_1,
    input  wire                      rst_n_sync,
    input  wire                      scan_in,
    input  wire                      hdr_shift,
    input  wire                      data_shift,
    input  wire                      out_load,
    input  wire                      out_shift,
    input  wire mem_pkg::data_word_t rdata,
    output logic                     hdr_we,
    output mem_pkg::word_cnt_t       hdr_cnt,
    output mem_pkg::word_addr_t      hdr_addr,
    output mem_pkg::data_word_t      scan_wdata,
    output logic                     scan_out
);
    import mem_pkg::*;

    logic [HDR_W-1:0] hdr_q;
    logic [HDR_W-1:0] hdr_view;
    data_word_t       data_q;
    data_word_t       out_q;

    // Serial fields arrive LSB first, entering at the top
    always_ff @(posedge clk_1) begin
        if (hdr_shift) begin
            hdr_q <= {scan_in, hdr_q[HDR_W-1:1]};
        end
        if (data_shift) begin
            data_q <= {scan_in, data_q[WORD_W-1:1]};
        end
    end

    always_ff @(posedge clk_1 or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            out_q <= '0;
        end else if (out_load) begin
            out_q <= rdata;
        end else if (out_shift) begin
            out_q <= out_q >> 1;
        end
    end

    // Header as it stands after this edge, lets the final bit steer the FSM
    assign hdr_view = hdr_shift ? {scan_in, hdr_q[HDR_W-1:1]} : hdr_q;

    assign hdr_we     = hdr_view[0];
    assign hdr_cnt    = hdr_view[CNT_W:1];
    assign hdr_addr   = hdr_view[HDR_W-1:CNT_W+1];
    assign scan_wdata = data_q;
    assign scan_out   = out_q[0];

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module tb_mem_scan \
    -f verilog.f -o tb_mem_scan > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_mem_scan > sim.log 2>&1; cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0

// ==== verilog.f ====
rtl/mem_pkg.sv
rtl/byte_bank.sv
rtl/lane_router.sv
rtl/read_aligner.sv
rtl/scan_sequencer.sv
rtl/bit_counter.sv
rtl/scan_shifter.sv
rtl/mem_scan_top.sv
dv/clk_gen.sv
dv/tb_mem_scan.sv
